// ==== Makefile ====
# Verilator build and run for the load/store cluster testbench

VERILATOR ?= verilator
TOP       := lsu_cluster_tb
FILELIST  := compile.f
VFLAGS    := --binary --timing -j 0 --top-module $(TOP)
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := All tests passed!

# sources named in the file list plus the included headers
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== compile.f ====
+incdir+include
hdl/lsu_pkg.sv
hdl/lsu_dispatch.sv
hdl/mem_access_unit.sv
hdl/data_bank.sv
hdl/lsu_collect.sv
hdl/lsu_cluster.sv
sim/lsu_cluster_tb.sv

// ==== hdl/data_bank.sv ====
`timescale 1ns/10ps
`include "lsu_defines.svh"

module data_bank (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 mem_req,
  input  logic [`LSU_XLEN-1:0] mem_addr,
  input  logic [3:0]           mem_wstrb,
  input  logic [`LSU_XLEN-1:0] mem_wdata,
  output logic                 mem_ack,
  output logic [`LSU_XLEN-1:0] mem_rdata
);

  localparam int IDX_BITS = $clog2(`LSU_BANK_WORDS);
  localparam int IDX_LSB  = 2 + $clog2(`LSU_LANES); // skip byte and bank bits

  logic [`LSU_XLEN-1:0] mem [`LSU_BANK_WORDS];
  logic [IDX_BITS-1:0]  idx;

  assign idx = mem_addr[IDX_LSB +: IDX_BITS];

  initial begin
    for (int i = 0; i < `LSU_BANK_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_req) begin
      mem_rdata <= mem[idx]; // old contents on a write
      for (int b = 0; b < 4; b++) begin
        if (mem_wstrb[b]) mem[idx][b*8 +: 8] <= mem_wdata[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) mem_ack <= 1'b0;
    else       mem_ack <= mem_req;
  end

endmodule

// ==== hdl/lsu_cluster.sv ====
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_cluster import lsu_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       in_valid,
  output logic                       in_ready,
  input  mem_op_e                    in_op,
  input  logic [`LSU_XLEN-1:0]       in_addr,
  input  logic [`LSU_XLEN-1:0]       in_wdata,
  input  logic [`LSU_REG_BITS-1:0]   in_rd,
  output logic                       out_valid,
  input  logic                       out_ready,
  output logic [`LSU_REG_BITS-1:0]   out_rd,
  output logic [`LSU_XLEN-1:0]       out_data,
  output logic                       out_is_store
);

  // dispatcher to lanes, payload shared
  logic [`LSU_LANES-1:0]     lane_valid;
  logic [`LSU_LANES-1:0]     lane_ready;
  mem_op_e                   lane_op;
  logic [`LSU_XLEN-1:0]      lane_addr;
  logic [`LSU_XLEN-1:0]      lane_wdata;
  logic [`LSU_REG_BITS-1:0]  lane_rd;

  // lane to bank
  logic                      mem_req   [`LSU_LANES];
  logic [`LSU_XLEN-1:0]      mem_addr  [`LSU_LANES];
  logic [3:0]                mem_wstrb [`LSU_LANES];
  logic [`LSU_XLEN-1:0]      mem_wdata [`LSU_LANES];
  logic                      mem_ack   [`LSU_LANES];
  logic [`LSU_XLEN-1:0]      mem_rdata [`LSU_LANES];

  // lane to collector
  logic [`LSU_LANES-1:0]     res_valid;
  logic [`LSU_LANES-1:0]     res_ready;
  logic [`LSU_REG_BITS-1:0]  res_rd       [`LSU_LANES];
  logic [`LSU_XLEN-1:0]      res_data     [`LSU_LANES];
  logic                      res_is_store [`LSU_LANES];

  lsu_dispatch lsu_dispatch_i (
    .clk(clk), .reset(reset),
    .in_valid(in_valid), .in_ready(in_ready),
    .in_op(in_op), .in_addr(in_addr), .in_wdata(in_wdata), .in_rd(in_rd),
    .lane_valid(lane_valid), .lane_ready(lane_ready),
    .lane_op(lane_op), .lane_addr(lane_addr), .lane_wdata(lane_wdata), .lane_rd(lane_rd)
  );

  for (genvar i = 0; i < `LSU_LANES; i++) begin : g_lane
    mem_access_unit mem_access_unit_i (
      .clk(clk), .reset(reset),
      .op_valid(lane_valid[i]), .op_ready(lane_ready[i]),
      .op(lane_op), .addr(lane_addr), .wdata(lane_wdata), .rd(lane_rd),
      .mem_req(mem_req[i]), .mem_addr(mem_addr[i]),
      .mem_wstrb(mem_wstrb[i]), .mem_wdata(mem_wdata[i]),
      .mem_ack(mem_ack[i]), .mem_rdata(mem_rdata[i]),
      .res_valid(res_valid[i]), .res_ready(res_ready[i]),
      .res_rd(res_rd[i]), .res_data(res_data[i]), .res_is_store(res_is_store[i])
    );

    data_bank data_bank_i (
      .clk(clk), .reset(reset),
      .mem_req(mem_req[i]), .mem_addr(mem_addr[i]),
      .mem_wstrb(mem_wstrb[i]), .mem_wdata(mem_wdata[i]),
      .mem_ack(mem_ack[i]), .mem_rdata(mem_rdata[i])
    );
  end

  lsu_collect lsu_collect_i (
    .clk(clk), .reset(reset),
    .res_valid(res_valid), .res_ready(res_ready),
    .res_rd(res_rd), .res_data(res_data), .res_is_store(res_is_store),
    .out_valid(out_valid), .out_ready(out_ready),
    .out_rd(out_rd), .out_data(out_data), .out_is_store(out_is_store)
  );

endmodule

// ==== hdl/lsu_collect.sv ====
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_collect (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`LSU_LANES-1:0]      res_valid,
  output logic [`LSU_LANES-1:0]      res_ready,
  input  logic [`LSU_REG_BITS-1:0]   res_rd       [`LSU_LANES],
  input  logic [`LSU_XLEN-1:0]       res_data     [`LSU_LANES],
  input  logic                       res_is_store [`LSU_LANES],
  output logic                       out_valid,
  input  logic                       out_ready,
  output logic [`LSU_REG_BITS-1:0]   out_rd,
  output logic [`LSU_XLEN-1:0]       out_data,
  output logic                       out_is_store
);

  localparam int LANE_BITS = $clog2(`LSU_LANES);

  logic [LANE_BITS-1:0] ptr;       // highest-priority lane this cycle
  logic [LANE_BITS-1:0] grant_idx;
  logic                 found;
  logic                 take;

  // output register free or draining
  assign take = !out_valid || out_ready;

  // first valid lane at or after ptr
  always_comb begin
    logic [LANE_BITS-1:0] cand;
    found     = 1'b0;
    grant_idx = ptr;
    for (int k = 0; k < `LSU_LANES; k++) begin
      cand = ptr + LANE_BITS'(k);
      if (!found && res_valid[cand]) begin
        found     = 1'b1;
        grant_idx = cand;
      end
    end
  end

  assign res_ready = (found && take) ? (`LSU_LANES'(1) << grant_idx) : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      ptr       <= '0;
    end else if (take) begin
      out_valid <= found;
      if (found) ptr <= grant_idx + 1'b1; // winner drops to lowest priority
    end
  end

  always_ff @(posedge clk) begin
    if (found && take) begin
      out_rd       <= res_rd[grant_idx];
      out_data     <= res_data[grant_idx];
      out_is_store <= res_is_store[grant_idx];
    end
  end

endmodule

// ==== hdl/lsu_dispatch.sv ====
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_dispatch import lsu_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       in_valid,
  output logic                       in_ready,
  input  mem_op_e                    in_op,
  input  logic [`LSU_XLEN-1:0]       in_addr,
  input  logic [`LSU_XLEN-1:0]       in_wdata,
  input  logic [`LSU_REG_BITS-1:0]   in_rd,
  output logic [`LSU_LANES-1:0]      lane_valid,
  input  logic [`LSU_LANES-1:0]      lane_ready,
  output mem_op_e                    lane_op,
  output logic [`LSU_XLEN-1:0]       lane_addr,
  output logic [`LSU_XLEN-1:0]       lane_wdata,
  output logic [`LSU_REG_BITS-1:0]   lane_rd
);

  localparam int LANE_BITS = $clog2(`LSU_LANES);

  logic                 full;
  logic [LANE_BITS-1:0] sel; // target lane, fixed at capture
  logic                 leave;
  logic                 take;

  // entry leaves once its lane takes it
  assign leave    = full && lane_ready[sel];
  assign in_ready = !full || leave;
  assign take     = in_valid && in_ready;

  assign lane_valid = full ? (`LSU_LANES'(1) << sel) : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (take) begin
      full <= 1'b1;
    end else if (leave) begin
      full <= 1'b0;
    end
  end

  // payload, only written on capture
  always_ff @(posedge clk) begin
    if (take) begin
      lane_op    <= in_op;
      lane_addr  <= in_addr;
      lane_wdata <= in_wdata;
      lane_rd    <= in_rd;
      sel        <= in_addr[2 +: LANE_BITS]; // word-interleaved banks
    end
  end

endmodule

// ==== hdl/lsu_pkg.sv ====
package lsu_pkg;

  // rv32 load/store opcodes as seen by the memory stage
  typedef enum logic [2:0] {
    OP_LB  = 3'd0,
    OP_LH  = 3'd1,
    OP_LW  = 3'd2,
    OP_LBU = 3'd3,
    OP_LHU = 3'd4,
    OP_SB  = 3'd5,
    OP_SH  = 3'd6,
    OP_SW  = 3'd7
  } mem_op_e;

  // memory-access lane states
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0, // ready for a new operation
    ST_LOAD  = 2'd1, // read issued, waiting for ack
    ST_STORE = 2'd2, // write issued, waiting for ack
    ST_DONE  = 2'd3  // result held for the collector
  } access_state_e;

endpackage

// ==== hdl/mem_access_unit.sv ====
`timescale 1ns/10ps
`include "lsu_defines.svh"

module mem_access_unit import lsu_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  // operation from the dispatcher
  input  logic                       op_valid,
  output logic                       op_ready,
  input  mem_op_e                    op,
  input  logic [`LSU_XLEN-1:0]       addr,
  input  logic [`LSU_XLEN-1:0]       wdata,
  input  logic [`LSU_REG_BITS-1:0]   rd,
  // bank side
  output logic                       mem_req,
  output logic [`LSU_XLEN-1:0]       mem_addr,
  output logic [3:0]                 mem_wstrb,
  output logic [`LSU_XLEN-1:0]       mem_wdata,
  input  logic                       mem_ack,
  input  logic [`LSU_XLEN-1:0]       mem_rdata,
  // result to the collector
  output logic                       res_valid,
  input  logic                       res_ready,
  output logic [`LSU_REG_BITS-1:0]   res_rd,
  output logic [`LSU_XLEN-1:0]       res_data,
  output logic                       res_is_store
);

  access_state_e        state;
  mem_op_e              op_q;
  logic [1:0]           off_q;      // byte offset in the word
  logic                 accept;
  logic                 is_store;
  logic [3:0]           st_strb;
  logic [`LSU_XLEN-1:0] st_data;
  logic [`LSU_XLEN-1:0] ld_data;
  logic [7:0]           ld_byte;
  logic [15:0]          ld_half;

  assign op_ready     = (state == ST_IDLE);
  assign accept       = op_valid && op_ready;
  assign is_store     = (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
  assign res_valid    = (state == ST_DONE);
  assign res_is_store = (op_q == OP_SB) || (op_q == OP_SH) || (op_q == OP_SW);

  // store strobe and lane replication
  always_comb begin
    st_strb = 4'b0000;
    st_data = wdata;
    case (op)
      OP_SW: st_strb = 4'b1111;
      OP_SH: begin
        st_strb = addr[1] ? 4'b1100 : 4'b0011;
        st_data = {2{wdata[15:0]}};
      end
      OP_SB: begin
        st_strb = 4'b0001 << addr[1:0];
        st_data = {4{wdata[7:0]}};
      end
      default: st_strb = 4'b0000; // loads read only
    endcase
  end

  // pick the addressed byte / halfword out of the read word
  assign ld_byte = mem_rdata[{off_q, 3'b000} +: 8];
  assign ld_half = off_q[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  always_comb begin
    case (op_q)
      OP_LB:   ld_data = {{24{ld_byte[7]}}, ld_byte};
      OP_LBU:  ld_data = {24'b0, ld_byte};
      OP_LH:   ld_data = {{16{ld_half[15]}}, ld_half};
      OP_LHU:  ld_data = {16'b0, ld_half};
      OP_LW:   ld_data = mem_rdata;
      default: ld_data = '0; // stores return zero
    endcase
  end

  // control
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ST_IDLE;
      mem_req <= 1'b0;
    end else begin
      mem_req <= 1'b0; // one-cycle request pulse
      case (state)
        ST_IDLE: begin
          if (op_valid) begin
            mem_req <= 1'b1;
            state   <= is_store ? ST_STORE : ST_LOAD;
          end
        end
        ST_LOAD, ST_STORE: begin
          if (mem_ack) state <= ST_DONE;
        end
        ST_DONE: begin
          if (res_ready) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // request payload, captured on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q      <= op;
      res_rd    <= rd;
      off_q     <= addr[1:0];
      mem_addr  <= {addr[`LSU_XLEN-1:2], 2'b00};
      mem_wstrb <= st_strb;
      mem_wdata <= st_data;
    end
  end

  // result payload
  always_ff @(posedge clk) begin
    if (mem_ack && (state == ST_LOAD || state == ST_STORE)) begin
      res_data <= ld_data;
    end
  end

endmodule

// ==== include/lsu_defines.svh ====
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// lanes and banks, one bank per lane
`define LSU_LANES 4

// data and address width
`define LSU_XLEN 32

// words per bank, indexed by address bits 9:4
`define LSU_BANK_WORDS 64

// destination register index width
`define LSU_REG_BITS 5

`endif

// ==== sim/lsu_cluster_tb.sv ====
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_cluster_tb import lsu_pkg::*; ();

  localparam int MEM_BYTES = 4 * `LSU_LANES * `LSU_BANK_WORDS; // whole banked space
  localparam int REGS      = 1 << `LSU_REG_BITS;
  localparam int TOTAL_OPS = 24 + 13 + 8 + 16 + 12 + 200;
  localparam int WATCHDOG_CYCLES = 20 * TOTAL_OPS + 200;

  logic                       clk = 1'b0;
  logic                       reset;
  logic                       in_valid;
  logic                       in_ready;
  mem_op_e                    in_op;
  logic [`LSU_XLEN-1:0]       in_addr;
  logic [`LSU_XLEN-1:0]       in_wdata;
  logic [`LSU_REG_BITS-1:0]   in_rd;
  logic                       out_valid;
  logic                       out_ready = 1'b0;
  logic [`LSU_REG_BITS-1:0]   out_rd;
  logic [`LSU_XLEN-1:0]       out_data;
  logic                       out_is_store;

  // reference memory and scoreboard keyed by rd
  logic [7:0]           ref_mem   [MEM_BYTES];
  logic [`LSU_XLEN-1:0] exp_data  [REGS];
  bit                   exp_store [REGS];
  int                   issued_cnt [REGS];
  int                   done_cnt   [REGS];
  int                   total_issued = 0;
  int                   total_done = 0;
  logic [`LSU_REG_BITS-1:0] next_rd = '0;

  // out_ready held low (0), high (1) or in a random pattern (2)
  int                   ready_mode = 1;
  logic                 ready_next = 1'b0;
  logic [63:0]          ready_pattern = '0;
  logic [5:0]           pat_idx = '0;

  lsu_cluster lsu_cluster_i (
    .clk(clk), .reset(reset),
    .in_valid(in_valid), .in_ready(in_ready),
    .in_op(in_op), .in_addr(in_addr), .in_wdata(in_wdata), .in_rd(in_rd),
    .out_valid(out_valid), .out_ready(out_ready),
    .out_rd(out_rd), .out_data(out_data), .out_is_store(out_is_store)
  );

  always #2 clk = ~clk;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      stop_on_error($sformatf("ERR %s expected 0x%08h got 0x%08h", name, expected, actual));
    end
  endtask

  function automatic bit is_store_op(input mem_op_e op);
    return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
  endfunction

  // applies a store to the reference bytes or returns the expected load value
  function automatic logic [31:0] predict_and_update(input mem_op_e op, input logic [31:0] addr,
                                                     input logic [31:0] wdata);
    int          wa;
    int          ha;
    int          ba;
    logic [15:0] half;
    logic [7:0]  byte_v;
    wa = int'(addr & 32'h0000_03fc);
    ha = wa + (addr[1] ? 2 : 0); // bit 0 ignored for halfwords
    ba = int'(addr & 32'h0000_03ff);
    half = {ref_mem[ha+1], ref_mem[ha]};
    byte_v = ref_mem[ba];
    predict_and_update = '0; // stores report zero data
    case (op)
      OP_SW: begin
        for (int b = 0; b < 4; b++) ref_mem[wa+b] = wdata[b*8 +: 8];
      end
      OP_SH: begin
        ref_mem[ha]   = wdata[7:0];
        ref_mem[ha+1] = wdata[15:8];
      end
      OP_SB:  ref_mem[ba] = wdata[7:0];
      OP_LW:  predict_and_update = {ref_mem[wa+3], ref_mem[wa+2], ref_mem[wa+1], ref_mem[wa]};
      OP_LH:  predict_and_update = {{16{half[15]}}, half};
      OP_LHU: predict_and_update = {16'b0, half};
      OP_LB:  predict_and_update = {{24{byte_v[7]}}, byte_v};
      OP_LBU: predict_and_update = {24'b0, byte_v};
      default: predict_and_update = '0;
    endcase
  endfunction

  // called on a falling edge and returns on the falling edge after the transfer
  task automatic issue_op(input mem_op_e op, input logic [31:0] addr, input logic [31:0] wdata);
    logic [`LSU_REG_BITS-1:0] rd;
    logic [`LSU_REG_BITS-1:0] cand;
    bit                       found;
    found = 1'b0;
    rd = next_rd;
    while (!found) begin
      for (int k = 0; k < REGS; k++) begin
        cand = next_rd + `LSU_REG_BITS'(k);
        if (!found && issued_cnt[cand] == done_cnt[cand]) begin
          rd = cand;
          found = 1'b1;
        end
      end
      if (!found) @(negedge clk);
    end
    next_rd  = rd + 1'b1;
    in_valid = 1'b1;
    in_op    = op;
    in_addr  = addr;
    in_wdata = wdata;
    in_rd    = rd;
    while (!in_ready) @(negedge clk);
    // transfer happens on the coming rising edge
    exp_data[rd]  = predict_and_update(op, addr, wdata);
    exp_store[rd] = is_store_op(op);
    issued_cnt[rd]++;
    total_issued++;
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (total_issued != total_done) @(negedge clk);
  endtask

  // completions may arrive in any order
  always @(posedge clk) begin
    if (!reset && out_valid && out_ready) begin
      if (issued_cnt[out_rd] == done_cnt[out_rd]) begin
        stop_on_error($sformatf("completion for rd %0d with nothing outstanding", out_rd));
      end else begin
        check_value("out_data", exp_data[out_rd], out_data);
        check_value("out_is_store", 32'(exp_store[out_rd]), 32'(out_is_store));
        done_cnt[out_rd]++;
        total_done++;
      end
    end
  end

  // mode sampled on the rising edge and applied on the falling edge
  always @(posedge clk) begin
    case (ready_mode)
      0: ready_next = 1'b0;
      1: ready_next = 1'b1;
      default: begin
        ready_next = ready_pattern[pat_idx];
        pat_idx = pat_idx + 6'd1;
      end
    endcase
  end

  always @(negedge clk) out_ready = ready_next;

  task automatic word_store_load();
    logic [31:0] addr;
    for (int bank = 0; bank < 4; bank++) begin
      for (int k = 0; k < 3; k++) begin
        addr = 32'(k * 272 + bank * 4); // 0x110 steps keep the bank and change the row
        issue_op(OP_SW, addr, {addr[15:0] ^ 16'ha5c3, 16'h1000 + addr[15:0]});
        issue_op(OP_LW, addr, 32'h0);
      end
    end
    wait_drain();
  endtask

  task automatic byte_access();
    logic [7:0]  pattern [4] = '{8'h81, 8'h7f, 8'hc3, 8'h2a};
    logic [31:0] base;
    base = 32'h0000_0100;
    for (int b = 0; b < 4; b++) issue_op(OP_SB, base + 32'(b), {24'hdeadbe, pattern[b]});
    for (int b = 0; b < 4; b++) begin
      issue_op(OP_LB, base + 32'(b), 32'h0);
      issue_op(OP_LBU, base + 32'(b), 32'h0);
    end
    issue_op(OP_LW, base, 32'h0); // merged word
    wait_drain();
  endtask

  task automatic halfword_access();
    logic [31:0] base;
    base = 32'h0000_0208; // bank 2
    issue_op(OP_SH, base, 32'h1234_8001);
    issue_op(OP_SH, base + 32'd2, 32'h0000_f00d);
    issue_op(OP_LH, base, 32'h0);
    issue_op(OP_LHU, base, 32'h0);
    issue_op(OP_LH, base + 32'd2, 32'h0);
    issue_op(OP_LHU, base + 32'd2, 32'h0);
    issue_op(OP_LH, base + 32'd3, 32'h0); // bit 0 ignored
    issue_op(OP_LW, base, 32'h0);
    wait_drain();
  endtask

  task automatic parallel_bank_loads();
    ready_mode = 1;
    for (int i = 0; i < 16; i++) issue_op(OP_LW, 32'h0000_0100 + 32'(i * 4), 32'h0);
    wait_drain();
  endtask

  task automatic back_pressure();
    bit saw_stall;
    saw_stall = 1'b0;
    ready_mode = 0;
    fork
      begin
        for (int i = 0; i < 12; i++) begin
          if (i < 6) issue_op(OP_SW, 32'h380 + 32'(i * 4), 32'h5a5a_5a5a ^ 32'(i * 32'h0101_0101));
          else       issue_op(OP_LW, 32'h380 + 32'((i - 6) * 4), 32'h0);
        end
      end
      begin
        repeat (40) begin
          @(negedge clk);
          if (!in_ready) saw_stall = 1'b1;
        end
        ready_mode = 1; // release the writeback port
      end
    join
    if (!saw_stall) stop_on_error("in_ready never dropped while out_ready was held low");
    wait_drain();
  endtask

  task automatic random_mix();
    mem_op_e     op;
    logic [31:0] addr;
    ready_mode = 2;
    for (int i = 0; i < 200; i++) begin
      op = mem_op_e'(3'($urandom % 8));
      addr = $urandom % MEM_BYTES;
      issue_op(op, addr, $urandom);
    end
    ready_mode = 1;
    wait_drain();
  endtask

  initial begin
    void'($urandom(97572));
    ready_pattern = {$urandom, $urandom};
    for (int i = 0; i < MEM_BYTES; i++) ref_mem[i] = 8'h00;
    for (int r = 0; r < REGS; r++) begin
      issued_cnt[r] = 0;
      done_cnt[r] = 0;
    end
    reset    = 1'b1;
    in_valid = 1'b0;
    in_op    = OP_LW;
    in_addr  = '0;
    in_wdata = '0;
    in_rd    = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_value("in_ready", 32'd1, 32'(in_ready));
    check_value("out_valid", 32'd0, 32'(out_valid));
    word_store_load();
    byte_access();
    halfword_access();
    parallel_bank_loads();
    back_pressure();
    random_mix();
    $display("All tests passed!");
    $finish;
  end

  // run length bound from the operation count
  initial begin
    repeat (WATCHDOG_CYCLES + 10) @(posedge clk);
    stop_on_error($sformatf("timeout with %0d of %0d issued operations completed",
                            total_done, total_issued));
  end

endmodule
